// File: bench/issue_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module issue_asserts import issue_pkg::*; (
    input  wire          aclk,
    input  wire          rst_n,
    input  wire          push,
    input  wire          pop,
    input  wire          full,
    input  wire          empty,
    input  wire          reg_valid,
    input  wire          id_allowin,
    input  ctrl_state_t  state
);

    a_push_full : assert property (@(posedge aclk) disable iff (!rst_n) !(push && full))
        else $error("push asserted while the queue is full");

    a_pop_empty : assert property (@(posedge aclk) disable iff (!rst_n) !(pop && empty))
        else $error("pop asserted while the queue is empty");

    // One flush cycle leaves the stage register and the queue empty
    a_flush_one : assert property (@(posedge aclk) disable iff (!rst_n)
                                   state == FLUSH |=> state == RUN && empty && !reg_valid)
        else $error("FLUSH lasted more than one cycle or left pairs behind");

    a_flush_allowin : assert property (@(posedge aclk) disable iff (!rst_n)
                                       state == FLUSH |-> !id_allowin)
        else $error("id_allowin high during FLUSH");

endmodule

bind issue_ctrl issue_asserts u_issue_asserts (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .push       (push),
    .pop        (pop),
    .full       (full),
    .empty      (empty),
    .reg_valid  (reg_valid),
    .id_allowin (id_allowin),
    .state      (state)
);

`default_nettype wire

// File: bench/tb_issue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_issue import issue_pkg::*; ();

    localparam int QUEUE_DEPTH   = 4;
    localparam int TEST_CYCLES   = 12 + 60 + 30 + 80 + 40;   // Reset and the five tests
    localparam int MARGIN_CYCLES = 100;

    logic       aclk = 1'b0;
    logic       rst_n, flush, id_readygo, issue_allowin;
    logic       id_allowin, iq_valid;
    pc_t        in_pc0, in_pc1;
    uop_t       in_uop0, in_uop1;
    imm_t       in_imm0, in_imm1;
    reg_idx_t   in_rd0, in_rd1, in_rj0, in_rj1, in_rk0, in_rk1;
    kind_t      in_kind0, in_kind1;
    logic       in_excp_valid, in_branch;
    excp_code_t in_excp_code;
    pair_t      iq_pair;

    logic [31:0] lfsr = 32'he299_c6ca;

    // Reference model state, one step ahead of the DUT between a falling and a rising edge
    pair_t model_q[$];
    pair_t stage_p;
    logic  stage_v     = 1'b0;
    logic  flushing    = 1'b0;
    int    acc_count   = 0;
    int    pop_count   = 0;
    int    mon_errors  = 0;
    int    mon_checks  = 0;
    int    test_errors = 0;
    int    test_checks = 0;

    always #10 aclk = ~aclk;

    issue_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) dut0 (.*);

    // ##################################################
    // Helpers
    // ##################################################

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    // Slot 0, slot 1, then the pair fields
    function automatic pair_t make_pair();
        return {in_pc0, in_uop0, in_imm0, in_rd0, in_rj0, in_rk0, in_kind0,
                in_pc1, in_uop1, in_imm1, in_rd1, in_rj1, in_rk1, in_kind1,
                in_excp_valid, in_excp_code, in_branch};
    endfunction

    function automatic int report_mismatch(input string name, input pair_t got,
                                           input pair_t want);
        $display("** Error at %0d ns: %s is %0h, expected %0h", $time, name, got, want);
        return 1;
    endfunction

    task automatic step();
        @(posedge aclk);
        in_pc0        <= rand_bits(32);
        in_uop0       <= uop_t'(rand_bits(UOP_W));
        in_imm0       <= rand_bits(32);
        in_rd0        <= reg_idx_t'(rand_bits(5));
        in_rj0        <= reg_idx_t'(rand_bits(5));
        in_rk0        <= reg_idx_t'(rand_bits(5));
        in_kind0      <= kind_t'(rand_bits(4));
        in_pc1        <= rand_bits(32);
        in_uop1       <= uop_t'(rand_bits(UOP_W));
        in_imm1       <= rand_bits(32);
        in_rd1        <= reg_idx_t'(rand_bits(5));
        in_rj1        <= reg_idx_t'(rand_bits(5));
        in_rk1        <= reg_idx_t'(rand_bits(5));
        in_kind1      <= kind_t'(rand_bits(4));
        in_excp_valid <= 1'(rand_bits(1));
        in_excp_code  <= excp_code_t'(rand_bits(7));
        in_branch     <= 1'(rand_bits(1));
    endtask

    task automatic drain();
        id_readygo    <= 1'b0;
        issue_allowin <= 1'b1;
        while (model_q.size() != 0 || stage_v) begin
            step();
        end
        step();
    endtask

    // ##################################################
    // Comparison against the reference model
    // ##################################################

    always @(negedge aclk) begin : compare
        logic exp_valid;
        logic exp_allowin;
        logic do_push;
        if (rst_n) begin
            exp_valid   = !flushing && model_q.size() > 0;
            exp_allowin = !flushing && (!stage_v || model_q.size() < QUEUE_DEPTH);
            do_push     = !flushing && stage_v && model_q.size() < QUEUE_DEPTH;
            mon_checks += 2;
            if (iq_valid !== exp_valid)
                mon_errors += report_mismatch("iq_valid", pair_t'(iq_valid), pair_t'(exp_valid));
            if (id_allowin !== exp_allowin)
                mon_errors += report_mismatch("id_allowin", pair_t'(id_allowin),
                                              pair_t'(exp_allowin));
            if (iq_valid && issue_allowin) begin
                mon_checks++;
                pop_count++;
                if (model_q.size() == 0) begin
                    mon_errors++;
                    $display("Pair issued at %0d ns while none was expected", $time);
                end else begin
                    if (iq_pair !== model_q[0])
                        mon_errors += report_mismatch("iq_pair", iq_pair, model_q[0]);
                    void'(model_q.pop_front());
                end
            end
            if (do_push)
                model_q.push_back(stage_p);
            if (id_readygo && exp_allowin) begin
                stage_p = make_pair();
                stage_v = 1'b1;
                acc_count++;
            end else if (do_push) begin
                stage_v = 1'b0;                     // Bubble
            end
            if (flushing) begin
                model_q.delete();
                stage_v  = 1'b0;
                flushing = 1'b0;
            end else if (flush) begin
                flushing = 1'b1;
            end
        end
    end

    // ##################################################
    // Tests
    // ##################################################

    initial begin : run_tests
        int base_acc;
        int base_pop;
        rst_n         <= 1'b0;
        flush         <= 1'b0;
        id_readygo    <= 1'b0;
        issue_allowin <= 1'b0;
        {in_pc0, in_uop0, in_imm0, in_rd0, in_rj0, in_rk0, in_kind0,
         in_pc1, in_uop1, in_imm1, in_rd1, in_rj1, in_rk1, in_kind1,
         in_excp_valid, in_excp_code, in_branch} <= '0;
        repeat (10) @(posedge aclk);
        rst_n <= 1'b1;

        @(negedge aclk);
        test_checks += 2;
        if (iq_valid !== 1'b0)
            test_errors += report_mismatch("iq_valid", pair_t'(iq_valid), pair_t'(1'b0));
        if (id_allowin !== 1'b1)
            test_errors += report_mismatch("id_allowin", pair_t'(id_allowin), pair_t'(1'b1));
        $display("Test 1 reset state done, %0d errors so far", mon_errors + test_errors);

        step();
        id_readygo    <= 1'b1;
        issue_allowin <= 1'b1;
        base_acc = acc_count;
        base_pop = pop_count;
        @(negedge aclk);                            // First pair is offered here
        test_checks += 4;
        if (id_allowin !== 1'b1)
            test_errors += report_mismatch("id_allowin", pair_t'(id_allowin), pair_t'(1'b1));
        step();
        @(negedge aclk);
        if (iq_valid !== 1'b0)
            test_errors += report_mismatch("iq_valid", pair_t'(iq_valid), pair_t'(1'b0));
        step();
        @(negedge aclk);
        if (iq_valid !== 1'b1)
            test_errors += report_mismatch("iq_valid", pair_t'(iq_valid), pair_t'(1'b1));
        step();
        while (acc_count < base_acc + 40) begin
            step();
        end
        drain();
        if (pop_count - base_pop != 40)
            test_errors += report_mismatch("issued pairs", pair_t'(pop_count - base_pop),
                                           pair_t'(40));
        $display("Test 2 streaming done, %0d errors so far", mon_errors + test_errors);

        base_acc = acc_count;
        id_readygo    <= 1'b1;
        issue_allowin <= 1'b0;
        do begin
            step();
            @(negedge aclk);
        end while (id_allowin);
        step();
        test_checks++;
        if (acc_count - base_acc != QUEUE_DEPTH + 1)
            test_errors += report_mismatch("accepted pairs", pair_t'(acc_count - base_acc),
                                           pair_t'(QUEUE_DEPTH + 1));
        drain();
        $display("Test 3 back-pressure done, %0d errors so far", mon_errors + test_errors);

        base_acc = acc_count;
        base_pop = pop_count;
        repeat (60) begin
            step();
            id_readygo    <= 1'(rand_bits(1));
            issue_allowin <= 1'(rand_bits(1));
        end
        drain();
        test_checks++;
        if (pop_count - base_pop != acc_count - base_acc)
            test_errors += report_mismatch("issued pairs", pair_t'(pop_count - base_pop),
                                           pair_t'(acc_count - base_acc));
        $display("Test 4 bubbles done, %0d errors so far", mon_errors + test_errors);

        id_readygo    <= 1'b1;
        issue_allowin <= 1'b0;
        repeat (3) step();                          // Three pairs left in flight
        flush      <= 1'b1;
        id_readygo <= 1'b0;
        step();
        flush <= 1'b0;
        @(negedge aclk);
        test_checks += 2;
        if (iq_valid !== 1'b0)
            test_errors += report_mismatch("iq_valid", pair_t'(iq_valid), pair_t'(1'b0));
        step();
        base_acc = acc_count;
        base_pop = pop_count;
        id_readygo    <= 1'b1;
        issue_allowin <= 1'b1;
        while (acc_count < base_acc + 8) begin
            step();
        end
        drain();
        if (pop_count - base_pop != 8)
            test_errors += report_mismatch("issued pairs", pair_t'(pop_count - base_pop),
                                           pair_t'(8));
        $display("Test 5 flush done, %0d errors so far", mon_errors + test_errors);

        $display("Checks %0d, errors %0d, pairs issued %0d", mon_checks + test_checks,
                 mon_errors + test_errors, pop_count);
        if (mon_errors + test_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    initial begin : watchdog
        #((TEST_CYCLES + MARGIN_CYCLES) * 20);
        $display("Watchdog expired after %0d cycles and the tests did not finish",
                 TEST_CYCLES + MARGIN_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: common/issue_pkg.sv
`default_nettype none

package issue_pkg;

    // ##################################################
    // Field widths and types
    // ##################################################

    localparam int UOP_W = 8;

    typedef logic [31:0]      pc_t;
    typedef logic [UOP_W-1:0] uop_t;
    typedef logic [31:0]      imm_t;
    typedef logic [4:0]       reg_idx_t;
    typedef logic [3:0]       kind_t;      // Bit 0 alu, 1 syscall, 2 break, 3 privileged
    typedef logic [6:0]       excp_code_t;

    // One slot is pc, uop, imm, rd, rj, rk, kind from the top bit down
    localparam int SLOT_W = $bits(pc_t) + $bits(uop_t) + $bits(imm_t)
                          + 3 * $bits(reg_idx_t) + $bits(kind_t);

    // Slot 0, slot 1, then exception valid, exception code and branch flag
    localparam int PAIR_W = 2 * SLOT_W + 1 + $bits(excp_code_t) + 1;

    typedef logic [PAIR_W-1:0] pair_t;

    // ##################################################
    // Control states
    // ##################################################

    typedef enum logic {
        RUN,
        FLUSH
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: common/slot_if.sv
`timescale 1ns/1ps
`default_nettype none

// Fields of one decoded instruction slot
interface slot_if import issue_pkg::*; ();

    pc_t      pc;
    uop_t     uop;
    imm_t     imm;
    reg_idx_t rd;
    reg_idx_t rj;
    reg_idx_t rk;
    kind_t    kind;

    modport src (output pc, uop, imm, rd, rj, rk, kind);

    modport dst (input pc, uop, imm, rd, rj, rk, kind);

endinterface

`default_nettype wire

// File: design/issue_top.sv
`timescale 1ns/1ps
`default_nettype none

module issue_top import issue_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire         aclk,
    input  wire         rst_n,
    input  wire         flush,
    input  wire         id_readygo,
    input  wire         issue_allowin,
    output logic        id_allowin,
    output logic        iq_valid,
    input  pc_t         in_pc0,
    input  pc_t         in_pc1,
    input  uop_t        in_uop0,
    input  uop_t        in_uop1,
    input  imm_t        in_imm0,
    input  imm_t        in_imm1,
    input  reg_idx_t    in_rd0,
    input  reg_idx_t    in_rd1,
    input  reg_idx_t    in_rj0,
    input  reg_idx_t    in_rj1,
    input  reg_idx_t    in_rk0,
    input  reg_idx_t    in_rk1,
    input  kind_t       in_kind0,
    input  kind_t       in_kind1,
    input  wire         in_excp_valid,
    input  excp_code_t  in_excp_code,
    input  wire         in_branch,
    output pair_t       iq_pair
);

    logic       reg_valid;
    logic       push;
    logic       pop;
    logic       full;
    logic       empty;
    logic       flush_now;
    logic       excp_valid;
    excp_code_t excp_code;
    logic       branch;

    slot_if slot0_if ();
    slot_if slot1_if ();

    // ##################################################
    // Stage register and queue
    // ##################################################

    id_stage_reg u_id_stage_reg (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .flush_now     (flush_now),
        .id_readygo    (id_readygo),
        .id_allowin    (id_allowin),
        .push          (push),
        .in_pc0        (in_pc0),
        .in_pc1        (in_pc1),
        .in_uop0       (in_uop0),
        .in_uop1       (in_uop1),
        .in_imm0       (in_imm0),
        .in_imm1       (in_imm1),
        .in_rd0        (in_rd0),
        .in_rd1        (in_rd1),
        .in_rj0        (in_rj0),
        .in_rj1        (in_rj1),
        .in_rk0        (in_rk0),
        .in_rk1        (in_rk1),
        .in_kind0      (in_kind0),
        .in_kind1      (in_kind1),
        .in_excp_valid (in_excp_valid),
        .in_excp_code  (in_excp_code),
        .in_branch     (in_branch),
        .reg_valid     (reg_valid),
        .excp_valid    (excp_valid),
        .excp_code     (excp_code),
        .branch        (branch),
        .slot0         (slot0_if.src),
        .slot1         (slot1_if.src)
    );

    issue_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_issue_queue (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .flush_now  (flush_now),
        .push       (push),
        .pop        (pop),
        .slot0      (slot0_if.dst),
        .slot1      (slot1_if.dst),
        .excp_valid (excp_valid),
        .excp_code  (excp_code),
        .branch     (branch),
        .head       (iq_pair)
    );

    // ##################################################
    // Control
    // ##################################################

    occupancy_counter #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_occupancy_counter (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .flush_now (flush_now),
        .push      (push),
        .pop       (pop),
        .full      (full),
        .empty     (empty)
    );

    issue_ctrl u_issue_ctrl (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .flush         (flush),
        .reg_valid     (reg_valid),
        .full          (full),
        .empty         (empty),
        .issue_allowin (issue_allowin),
        .push          (push),
        .pop           (pop),
        .id_allowin    (id_allowin),
        .iq_valid      (iq_valid),
        .flush_now     (flush_now)
    );

endmodule

`default_nettype wire

// File: issue/id_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_reg import issue_pkg::*; (
    input  wire         aclk,
    input  wire         rst_n,
    input  wire         flush_now,
    input  wire         id_readygo,
    input  wire         id_allowin,
    input  wire         push,
    input  pc_t         in_pc0,
    input  pc_t         in_pc1,
    input  uop_t        in_uop0,
    input  uop_t        in_uop1,
    input  imm_t        in_imm0,
    input  imm_t        in_imm1,
    input  reg_idx_t    in_rd0,
    input  reg_idx_t    in_rd1,
    input  reg_idx_t    in_rj0,
    input  reg_idx_t    in_rj1,
    input  reg_idx_t    in_rk0,
    input  reg_idx_t    in_rk1,
    input  kind_t       in_kind0,
    input  kind_t       in_kind1,
    input  wire         in_excp_valid,
    input  excp_code_t  in_excp_code,
    input  wire         in_branch,
    output logic        reg_valid,
    output logic        excp_valid,
    output excp_code_t  excp_code,
    output logic        branch,
    slot_if.src         slot0,
    slot_if.src         slot1
);

    logic  accept;
    pair_t pair_r;

    assign accept = id_readygo && id_allowin;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            reg_valid <= 1'b0;
            pair_r    <= '0;
        end else if (flush_now || (push && !accept)) begin   // Bubble when nothing follows
            reg_valid <= 1'b0;
            pair_r    <= '0;
        end else if (accept) begin
            reg_valid <= 1'b1;
            pair_r    <= {in_pc0, in_uop0, in_imm0, in_rd0, in_rj0, in_rk0, in_kind0,
                          in_pc1, in_uop1, in_imm1, in_rd1, in_rj1, in_rk1, in_kind1,
                          in_excp_valid, in_excp_code, in_branch};
        end
    end

    // Same field order as pair_t
    assign {slot0.pc, slot0.uop, slot0.imm, slot0.rd, slot0.rj, slot0.rk, slot0.kind,
            slot1.pc, slot1.uop, slot1.imm, slot1.rd, slot1.rj, slot1.rk, slot1.kind,
            excp_valid, excp_code, branch} = pair_r;

endmodule

`default_nettype wire

// File: issue/issue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl import issue_pkg::*; (
    input  wire   aclk,
    input  wire   rst_n,
    input  wire   flush,
    input  wire   reg_valid,
    input  wire   full,
    input  wire   empty,
    input  wire   issue_allowin,
    output logic  push,
    output logic  pop,
    output logic  id_allowin,
    output logic  iq_valid,
    output logic  flush_now
);

    ctrl_state_t state;
    logic        run;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= RUN;
        end else if (state == FLUSH) begin
            state <= RUN;            // Flush takes exactly one cycle
        end else if (flush) begin
            state <= FLUSH;
        end
    end

    assign run       = (state == RUN);
    assign flush_now = (state == FLUSH);

    // The stage register empties into the queue whenever there is room
    assign push       = run && reg_valid && !full;
    assign iq_valid   = run && !empty;
    assign pop        = iq_valid && issue_allowin;
    assign id_allowin = run && (!reg_valid || push);

endmodule

`default_nettype wire

// File: issue/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue import issue_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire         aclk,
    input  wire         rst_n,
    input  wire         flush_now,
    input  wire         push,
    input  wire         pop,
    slot_if.dst         slot0,
    slot_if.dst         slot1,
    input  wire         excp_valid,
    input  excp_code_t  excp_code,
    input  wire         branch,
    output pair_t       head
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    pair_t             mem [QUEUE_DEPTH];
    pair_t             wr_pair;
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;

    // ##################################################
    // Pack the stage register outputs
    // ##################################################

    assign wr_pair = {slot0.pc, slot0.uop, slot0.imm, slot0.rd, slot0.rj, slot0.rk,
                      slot0.kind,
                      slot1.pc, slot1.uop, slot1.imm, slot1.rd, slot1.rj, slot1.rk,
                      slot1.kind,
                      excp_valid, excp_code, branch};

    // ##################################################
    // Pointers and storage
    // ##################################################

    // Depth is a power of two so the pointers wrap by themselves
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush_now) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= wr_pair;
        end
    end

    assign head = mem[rd_ptr];   // Only meaningful while iq_valid is high

endmodule

`default_nettype wire

// File: issue/occupancy_counter.sv
`timescale 1ns/1ps
`default_nettype none

module occupancy_counter #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire   aclk,
    input  wire   rst_n,
    input  wire   flush_now,
    input  wire   push,
    input  wire   pop,
    output logic  full,
    output logic  empty
);

    // One extra bit so that a full queue is representable
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (flush_now) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Idle, or push and pop together
            endcase
        end
    end

    assign full  = (count == CNT_W'(QUEUE_DEPTH));
    assign empty = (count == '0);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the issue path testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -f sources.f --top-module tb_issue -o tb_issue
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_issue > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "** FAIL **" "$log"; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"
exit 0

// File: sources.f
common/issue_pkg.sv
common/slot_if.sv
issue/id_stage_reg.sv
issue/issue_queue.sv
issue/issue_ctrl.sv
issue/occupancy_counter.sv
design/issue_top.sv
bench/issue_asserts.sv
bench/tb_issue.sv
